// ==== branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor (
    input  rv32_isa_pkg::word_t fetch_word,
    output logic                predict_taken,
    output rv32_isa_pkg::word_t pc_offset
);
    import rv32_isa_pkg::*;

    opcode_t opcode;
    logic    sign;
    word_t   imm_j;
    word_t   imm_b;

    assign opcode = fetch_word[OPCODE_MSB:OPCODE_LSB];
    assign sign   = fetch_word[SIGN_BIT];   // imm sign bit for both J and B forms.

    // J immediate, a signed 21-bit byte offset with bit 0 always zero.
    assign imm_j = {
        {12{sign}},
        fetch_word[J_HI_MSB:J_HI_LSB],
        fetch_word[J_B11_POS],
        fetch_word[J_LO_MSB:J_LO_LSB],
        1'b0
    };

    // B immediate, a signed 13-bit byte offset with bit 0 always zero.
    assign imm_b = {
        {20{sign}},
        fetch_word[B_B11_POS],
        fetch_word[B_MID_MSB:B_MID_LSB],
        fetch_word[B_LO_MSB:B_LO_LSB],
        1'b0
    };

    // Backward taken, forward not taken; JAL is unconditional so it always redirects.
    always_comb begin
        if (opcode == OPCODE_JAL) begin
            predict_taken = 1'b1;
            pc_offset     = imm_j;
        end else if (opcode == OPCODE_BRANCH && sign) begin
            predict_taken = 1'b1;   // negative offset, most likely a loop back edge.
            pc_offset     = imm_b;
        end else begin
            predict_taken = 1'b0;
            pc_offset     = PC_STEP;
        end
    end

endmodule

// ==== fetch_assertions.sv ====
`timescale 1ns/1ps

module fetch_assertions (
    input logic                clk,
    input logic                rst_n,
    input logic                stall,
    input logic                flush,
    input rv32_isa_pkg::word_t pc_out,
    input rv32_isa_pkg::word_t instr_out,
    input logic                predicted_taken
);
    import rv32_isa_pkg::*;

    int unsigned failure_count = 0;   // number of property failures so far.

    // a stalled edge must leave the decode side untouched.
    assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> ($stable(instr_out) && $stable(pc_out)))
    else begin
        failure_count++;
        $error("fetch/decode register changed while stall was high");
    end

    // an unstalled flush squashes the word going to decode.
    assert property (@(posedge clk) disable iff (!rst_n)
        (!stall && flush) |=> (instr_out == INSTR_NOP))
    else begin
        failure_count++;
        $error("instr_out is not a NOP after a flush");
    end

    // No prediction can leave the stage while it is in reset.
    assert property (@(posedge clk) !rst_n |-> !predicted_taken)
    else begin
        failure_count++;
        $error("predicted_taken is high during reset");
    end

endmodule

bind fetch_top fetch_assertions u_fetch_assertions (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall           (stall),
    .flush           (flush),
    .pc_out          (pc_out),
    .instr_out       (instr_out),
    .predicted_taken (predicted_taken)
);

// ==== fetch_cfg_pkg.sv ====
package fetch_cfg_pkg;

    // First address fetched when reset is released.
    localparam rv32_isa_pkg::word_t RESET_PC = 32'h0000_0000;

    // The instruction store holds a small program only.
    localparam int MEM_WORDS = 64;

    // Width of a word index into the instruction store.
    localparam int MEM_ADDR_W = $clog2(MEM_WORDS);

    // Word index, taken from the byte address without its two low bits.
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

endpackage

// ==== fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen (
    input  logic                clk,
    input  logic                rst_n,

    // Controls from the hazard unit and the memory stage.
    input  logic                stall,
    input  logic                branch_mispredicted,
    input  rv32_isa_pkg::word_t branch_pc,

    // Offset chosen by the predictor for the word now being fetched.
    input  rv32_isa_pkg::word_t pc_offset,

    output rv32_isa_pkg::word_t fetch_pc
);
    import rv32_isa_pkg::*;
    import fetch_cfg_pkg::*;

    word_t next_pc;

    // A late-stage redirect overrides whatever the predictor queued up.
    assign fetch_pc = branch_mispredicted ? branch_pc : next_pc;

    // Under stall the selected pc is stored, so a redirect seen during
    // a stalled cycle is not lost once fetch resumes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            next_pc <= RESET_PC;
        end else if (stall) begin
            next_pc <= fetch_pc;
        end else begin
            next_pc <= fetch_pc + pc_offset;   // pc plus 4 or plus the predicted target.
        end
    end

endmodule

// ==== fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb;
    import rv32_isa_pkg::*;
    import fetch_cfg_pkg::*;

    localparam int unsigned SEED          = 32'ha6291553;
    localparam int          RESET_TIMEOUT = 50;

    logic      clk;
    logic      rst_n;
    logic      stall;
    logic      flush;
    logic      branch_mispredicted;
    word_t     branch_pc;
    logic      load_en;
    mem_addr_t load_addr;
    word_t     load_data;
    word_t     pc_out;
    word_t     instr_out;
    logic      predicted_taken;

    word_t program_words [$];   // word i is loaded at byte address 4*i.

    // One entry per cycle of the run.
    logic  row_stall [$];
    logic  row_flush [$];
    logic  row_misp [$];
    word_t row_bpc [$];
    logic  row_rnd [$];         // stall and flush drawn at random on these rows.
    string row_name [$];

    // Reference model state.
    word_t model_mem [MEM_WORDS];
    word_t model_next_pc;
    word_t exp_pc;
    word_t exp_instr;
    logic  exp_taken;

    int          word_errors;
    int          flag_errors;
    int          assert_errors;
    int          other_errors;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    fetch_top uut (
        .clk                 (clk),
        .rst_n               (rst_n),
        .stall               (stall),
        .flush               (flush),
        .branch_mispredicted (branch_mispredicted),
        .branch_pc           (branch_pc),
        .load_en             (load_en),
        .load_addr           (load_addr),
        .load_data           (load_data),
        .pc_out              (pc_out),
        .instr_out           (instr_out),
        .predicted_taken     (predicted_taken)
    );

    task automatic add_row(input logic s, input logic f, input logic m, input word_t bpc,
                           input logic rnd, input string name);
        row_stall.push_back(s);
        row_flush.push_back(f);
        row_misp.push_back(m);
        row_bpc.push_back(bpc);
        row_rnd.push_back(rnd);
        row_name.push_back(name);
    endtask

    task automatic build_tables();
        program_words.push_back(32'h0010_0093);   // 0x00 addi x1, x0, 1.
        program_words.push_back(32'h0020_0113);   // 0x04 addi x2, x0, 2.
        program_words.push_back(32'h0020_9663);   // 0x08 bne x1, x2, +12.
        program_words.push_back(32'h0080_006f);   // 0x0c jal x0, +8.
        program_words.push_back(32'h0011_8193);   // 0x10 addi x3, x3, 1.
        program_words.push_back(32'h0011_8193);   // 0x14 addi x3, x3, 1.
        program_words.push_back(32'hfe00_0ce3);   // 0x18 beq x0, x0, -8.
        program_words.push_back(32'h0030_0213);   // 0x1c addi x4, x0, 3.
        program_words.push_back(32'hff1f_f06f);   // 0x20 jal x0, -16.

        repeat (4) add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "sequential");
        add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "jal_forward");
        repeat (2) add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "loop_body");
        add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "backward_branch");
        add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "loop_body");
        repeat (2) add_row(1'b1, 1'b0, 1'b0, 32'h0, 1'b0, "stall_hold");
        add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "stall_release");
        add_row(1'b0, 1'b1, 1'b0, 32'h0, 1'b0, "flush");
        add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "after_flush");
        add_row(1'b0, 1'b0, 1'b1, 32'h1c, 1'b0, "redirect");
        add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "after_redirect");
        repeat (2) add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "jal_backward");
        add_row(1'b1, 1'b0, 1'b1, 32'h80, 1'b0, "redirect_in_stall");
        add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "after_stall_redirect");
        repeat (2) add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "unloaded");
        add_row(1'b1, 1'b1, 1'b0, 32'h0, 1'b0, "flush_in_stall");
        add_row(1'b0, 1'b0, 1'b1, 32'h0, 1'b0, "redirect_restart");
        repeat (3) add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "restart");
        repeat (12) add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b1, "random_controls");
        add_row(1'b0, 1'b1, 1'b1, 32'h18, 1'b0, "redirect_and_flush");
        repeat (3) add_row(1'b0, 1'b0, 1'b0, 32'h0, 1'b0, "drain");
    endtask

    // Static prediction straight from the RV32I encodings.
    task automatic predict(input word_t w, output logic taken, output word_t offset);
        logic [20:0] j_imm;
        logic [12:0] b_imm;
        j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
        b_imm = {w[31], w[7], w[30:25], w[11:8], 1'b0};
        if (w[6:0] == OPCODE_JAL) begin
            taken  = 1'b1;
            offset = {{11{j_imm[20]}}, j_imm};
        end else if (w[6:0] == OPCODE_BRANCH && w[31]) begin
            taken  = 1'b1;
            offset = {{19{b_imm[12]}}, b_imm};
        end else begin
            taken  = 1'b0;
            offset = PC_STEP;
        end
    endtask

    // Advances the model by one edge with the given controls in effect.
    task automatic model_step(input logic s, input logic f, input logic m, input word_t bpc);
        word_t fpc;
        word_t fword;
        word_t offset;
        logic  taken;
        fpc   = m ? bpc : model_next_pc;
        fword = model_mem[fpc[7:2]];
        predict(fword, taken, offset);
        if (s) begin
            model_next_pc = fpc;   // outputs hold, the chosen pc waits.
        end else begin
            model_next_pc = fpc + offset;
            exp_pc        = fpc;
            exp_taken     = taken;
            exp_instr     = f ? INSTR_NOP : fword;
        end
    endtask

    task automatic check_word(input string name, input string field,
                              input word_t expected, input word_t actual);
        if (actual !== expected) begin
            word_errors++;
            $display("MISMATCH %s %s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic check_flag(input string name, input string field,
                              input logic expected, input logic actual);
        if (actual !== expected) begin
            flag_errors++;
            $display("MISMATCH %s %s: expected %b, actual %b", name, field, expected, actual);
        end
    endtask

    task automatic check_outputs(input string name);
        check_word(name, "pc_out", exp_pc, pc_out);
        check_word(name, "instr_out", exp_instr, instr_out);
        check_flag(name, "predicted_taken", exp_taken, predicted_taken);
    endtask

    task automatic wait_for_reset(output logic released);
        int cycles;
        cycles = 0;
        while (rst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        released = (rst_n === 1'b1);
        if (!released) begin
            other_errors++;
            $display("Timeout: reset was not released within %0d cycles", RESET_TIMEOUT);
        end
    endtask

    // The stage is held in stall while the program goes in.
    task automatic load_program();
        for (int i = 0; i < program_words.size(); i++) begin
            @(posedge clk);
            load_en   <= 1'b1;
            load_addr <= mem_addr_t'(i);
            load_data <= program_words[i];
            model_mem[i] = program_words[i];
        end
        @(posedge clk);
        load_en <= 1'b0;
        @(negedge clk);
    endtask

    task automatic run_table();
        logic  s;
        logic  f;
        string last_name;
        check_outputs("reset_state");
        model_step(1'b1, 1'b0, 1'b0, 32'h0);   // stall stays high until the first row.
        last_name = "load_hold";
        for (int i = 0; i < row_name.size(); i++) begin
            s = row_stall[i];
            f = row_flush[i];
            if (row_rnd[i]) begin
                s = ($urandom() % 4) == 0;
                f = ($urandom() % 4) == 0;
            end
            @(posedge clk);
            stall               <= s;
            flush               <= f;
            branch_mispredicted <= row_misp[i];
            branch_pc           <= row_bpc[i];
            @(negedge clk);
            check_outputs(last_name);   // result of the edge that sampled the previous row.
            model_step(s, f, row_misp[i], row_bpc[i]);
            last_name = row_name[i];
        end
        @(posedge clk);
        stall               <= 1'b0;
        flush               <= 1'b0;
        branch_mispredicted <= 1'b0;
        @(negedge clk);
        check_outputs(last_name);
    endtask

    task automatic report_and_finish();
        assert_errors = uut.u_fetch_assertions.failure_count;
        $display({"errors: %0d word mismatches, %0d flag mismatches, ",
                  "%0d assertion failures, %0d other failures"},
                 word_errors, flag_errors, assert_errors, other_errors);
        if (word_errors == 0 && flag_errors == 0 && assert_errors == 0
            && other_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    endtask

    initial begin
        logic released;
        void'($urandom(SEED));
        word_errors         = 0;
        flag_errors         = 0;
        assert_errors       = 0;
        other_errors        = 0;
        stall               = 1'b1;
        flush               = 1'b0;
        branch_mispredicted = 1'b0;
        branch_pc           = '0;
        load_en             = 1'b0;
        load_addr           = '0;
        load_data           = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            model_mem[i] = INSTR_NOP;   // matches the cleared memory after reset.
        end
        model_next_pc = RESET_PC;
        exp_pc        = RESET_PC;
        exp_instr     = INSTR_NOP;
        exp_taken     = 1'b0;
        build_tables();
        wait_for_reset(released);
        if (released) begin
            load_program();
            run_table();
        end
        report_and_finish();
    end

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top (
    input  logic                     clk,
    input  logic                     rst_n,

    // Pipeline control from the hazard and memory stages.
    input  logic                     stall,
    input  logic                     flush,
    input  logic                     branch_mispredicted,
    input  rv32_isa_pkg::word_t      branch_pc,

    // Program load port.
    input  logic                     load_en,
    input  fetch_cfg_pkg::mem_addr_t load_addr,
    input  rv32_isa_pkg::word_t      load_data,

    // Fetch/decode register outputs.
    output rv32_isa_pkg::word_t      pc_out,
    output rv32_isa_pkg::word_t      instr_out,
    output logic                     predicted_taken
);
    import rv32_isa_pkg::*;

    word_t fetch_pc;
    word_t fetch_word;
    word_t pc_offset;
    logic  predict_taken;

    instr_mem u_instr_mem (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .fetch_pc   (fetch_pc),
        .fetch_word (fetch_word)
    );

    branch_predictor u_branch_predictor (
        .fetch_word    (fetch_word),
        .predict_taken (predict_taken),
        .pc_offset     (pc_offset)
    );

    fetch_pc_gen u_fetch_pc_gen (
        .clk                 (clk),
        .rst_n               (rst_n),
        .stall               (stall),
        .branch_mispredicted (branch_mispredicted),
        .branch_pc           (branch_pc),
        .pc_offset           (pc_offset),
        .fetch_pc            (fetch_pc)
    );

    if_id_reg u_if_id_reg (
        .clk             (clk),
        .rst_n           (rst_n),
        .stall           (stall),
        .flush           (flush),
        .fetch_pc        (fetch_pc),
        .fetch_word      (fetch_word),
        .predict_taken   (predict_taken),
        .pc_out          (pc_out),
        .instr_out       (instr_out),
        .predicted_taken (predicted_taken)
    );

endmodule

// ==== if_id_reg.sv ====
`timescale 1ns/1ps

module if_id_reg (
    input  logic                clk,
    input  logic                rst_n,

    input  logic                stall,
    input  logic                flush,

    // Fetch stage results for the current cycle.
    input  rv32_isa_pkg::word_t fetch_pc,
    input  rv32_isa_pkg::word_t fetch_word,
    input  logic                predict_taken,

    // Toward decode.
    output rv32_isa_pkg::word_t pc_out,
    output rv32_isa_pkg::word_t instr_out,
    output logic                predicted_taken
);
    import rv32_isa_pkg::*;
    import fetch_cfg_pkg::*;

    // Decode sees a bubble at the reset vector until the first real fetch lands.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_out          <= RESET_PC;
            instr_out       <= INSTR_NOP;
            predicted_taken <= 1'b0;
        end else if (!stall) begin
            pc_out          <= fetch_pc;
            predicted_taken <= predict_taken;
            if (flush) begin
                instr_out <= INSTR_NOP;   // squash the word but keep its pc.
            end else begin
                instr_out <= fetch_word;
            end
        end
    end

endmodule

// ==== instr_mem.sv ====
`timescale 1ns/1ps

module instr_mem (
    input  logic                    clk,
    input  logic                    rst_n,

    // Load port, driven by the testbench before the program runs.
    input  logic                    load_en,
    input  fetch_cfg_pkg::mem_addr_t load_addr,
    input  rv32_isa_pkg::word_t     load_data,

    // Fetch port.
    input  rv32_isa_pkg::word_t     fetch_pc,
    output rv32_isa_pkg::word_t     fetch_word
);
    import rv32_isa_pkg::*;
    import fetch_cfg_pkg::*;

    word_t     mem [MEM_WORDS];
    mem_addr_t rd_addr;

    // The byte address is word aligned, so bits 1:0 are dropped.
    assign rd_addr = fetch_pc[MEM_ADDR_W+1:2];

    // Reads are combinational so the predictor sees the word in the same cycle.
    assign fetch_word = mem[rd_addr];

    // Every location starts out as a bubble, so an unloaded slot runs as a NOP.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= INSTR_NOP;
            end
        end else if (load_en) begin
            mem[load_addr] <= load_data;   // visible to fetch from the next cycle.
        end
    end

endmodule

// ==== rv32_isa_pkg.sv ====
package rv32_isa_pkg;

    // One 32-bit instruction or byte address.
    typedef logic [31:0] word_t;

    // Major opcode field in bits 6:0 of every base instruction.
    typedef logic [6:0] opcode_t;

    // Bit positions of the fields the fetch stage decodes.
    localparam int OPCODE_MSB = 6;
    localparam int OPCODE_LSB = 0;
    localparam int SIGN_BIT   = 31;

    // J-type immediate pieces, imm[20|10:1|11|19:12] in the encoding.
    localparam int J_HI_MSB   = 19;   // imm[19:12] sits in bits 19:12.
    localparam int J_HI_LSB   = 12;
    localparam int J_B11_POS  = 20;   // imm[11] sits in bit 20.
    localparam int J_LO_MSB   = 30;   // imm[10:1] sits in bits 30:21.
    localparam int J_LO_LSB   = 21;

    // B-type immediate pieces, imm[12|10:5] and imm[4:1|11].
    localparam int B_B11_POS  = 7;    // imm[11] sits in bit 7.
    localparam int B_MID_MSB  = 30;   // imm[10:5] sits in bits 30:25.
    localparam int B_MID_LSB  = 25;
    localparam int B_LO_MSB   = 11;   // imm[4:1] sits in bits 11:8.
    localparam int B_LO_LSB   = 8;

    // Opcodes the static predictor looks at.
    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;

    // addi x0, x0, 0 is the canonical bubble.
    localparam word_t INSTR_NOP = 32'h0000_0013;

    // Sequential fetch advances one word at a time.
    localparam word_t PC_STEP = 32'd4;

endpackage

// ==== src.f ====
rv32_isa_pkg.sv
fetch_cfg_pkg.sv
instr_mem.sv
branch_predictor.sv
fetch_pc_gen.sv
if_id_reg.sv
fetch_top.sv
tb_clock_gen.sv
fetch_assertions.sv
fetch_tb.sv

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;   // released on the edge that ends the fifth cycle.
    end

endmodule
